/* src/arm_lite_pkg.sv */
package arm_lite_pkg;

  localparam int xlen_p           = 32;
  localparam int reg_addr_width_p = 4;
  localparam int pc_reg_p         = 15;

  // the instruction class sits in bits 27:25 of the word.
  typedef enum logic [2:0] {
    dp_class     = 3'b000,
    mem_class    = 3'b010,
    branch_class = 3'b101
  } inst_class_e;

  typedef enum logic [3:0] {
    and_op = 4'b0000,
    sub_op = 4'b0010,
    add_op = 4'b0100,
    orr_op = 4'b1100,
    mov_op = 4'b1101
  } dp_op_e;

  // data processing and store layout.
  typedef struct packed {
    logic [3:0]                  cond;
    inst_class_e                 inst_class;
    dp_op_e                      opcode;
    logic                        s;
    logic [reg_addr_width_p-1:0] rn;
    logic [reg_addr_width_p-1:0] rd;
    logic [7:0]                  rest;
    logic [reg_addr_width_p-1:0] rm;
  } inst_dp_s;

  typedef struct packed {
    logic [3:0]  cond;
    inst_class_e inst_class;
    logic        link; // bit 24 is the unsupported BL link bit.
    logic [23:0] offset24;
  } inst_br_s;

  typedef union packed {
    inst_dp_s dp;
    inst_br_s br;
  } inst_u;

  typedef struct packed {
    logic              valid;
    logic [xlen_p-1:0] pc;
    inst_u             inst;
  } fetch_s;

  typedef struct packed {
    logic                        valid;
    logic [xlen_p-1:0]           pc;
    inst_u                       inst;
    logic [xlen_p-1:0]           r1;
    logic [xlen_p-1:0]           r2;
    logic [reg_addr_width_p-1:0] r1_addr;
    logic [reg_addr_width_p-1:0] r2_addr;
    logic [reg_addr_width_p-1:0] rd_addr;
  } decode_s;

  typedef struct packed {
    logic                        en;
    logic [reg_addr_width_p-1:0] addr;
    logic [xlen_p-1:0]           data;
  } wb_s;

  typedef struct packed {
    logic              valid;
    logic [xlen_p-1:0] addr;
    logic [xlen_p-1:0] data;
  } store_s;

endpackage

/* src/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                                        clk_i
  , input  logic                                        reset_i
  , input  logic [arm_lite_pkg::reg_addr_width_p-1:0]   r1_addr_i
  , input  logic [arm_lite_pkg::reg_addr_width_p-1:0]   r2_addr_i
  , input  logic [arm_lite_pkg::xlen_p-1:0]             pc_i
  , input  arm_lite_pkg::wb_s                           wb_i
  , output logic [arm_lite_pkg::xlen_p-1:0]             r1_o
  , output logic [arm_lite_pkg::xlen_p-1:0]             r2_o
);
  import arm_lite_pkg::*;

  localparam int num_regs_lp = 2 ** reg_addr_width_p;

  logic [xlen_p-1:0] regs_r [num_regs_lp];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < num_regs_lp; i++) begin
        regs_r[i] <= '0;
      end
    end else if (wb_i.en) begin
      regs_r[wb_i.addr] <= wb_i.data;
    end
  end

  // pc first, then the value being written this cycle, then the array.
  function automatic logic [xlen_p-1:0] read_port(
    input logic [reg_addr_width_p-1:0] addr
  );
    logic [xlen_p-1:0] value;
    if (addr == reg_addr_width_p'(pc_reg_p))
      value = pc_i;
    else if (wb_i.en && wb_i.addr == addr)
      value = wb_i.data; // write-through for the instruction just behind.
    else
      value = regs_r[addr];
    return value;
  endfunction

  always_comb begin
    r1_o = read_port(r1_addr_i);
    r2_o = read_port(r2_addr_i);
  end

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                              clk_i
  , input  logic                              reset_i
  , input  logic                              flush_i
  , input  logic [arm_lite_pkg::xlen_p-1:0]   target_i
  , output logic                              imem_req_o
  , output logic [arm_lite_pkg::xlen_p-1:0]   imem_addr_o
  , input  logic                              imem_ack_i
  , input  logic [arm_lite_pkg::xlen_p-1:0]   imem_data_i
  , output arm_lite_pkg::fetch_s              fetch_o
);
  import arm_lite_pkg::*;

  typedef enum logic [1:0] {
    idle_st,
    wait_ack_st,
    wait_rel_st
  } state_e;

  state_e            state_r;
  logic [xlen_p-1:0] pc_r;
  logic [xlen_p-1:0] pc_next;
  logic              discard_r;
  logic              valid_r;
  logic [xlen_p-1:0] word_pc_r;
  logic [xlen_p-1:0] word_r;
  logic              accept;
  logic              deliver;
  logic              raise_req;

  assign accept    = (state_r == wait_ack_st) && imem_ack_i;
  assign deliver   = accept && !discard_r && !flush_i; // a flush at this edge kills the word.
  assign raise_req = (state_r != wait_ack_st) && !imem_ack_i;

  always_comb begin
    if (flush_i)
      pc_next = target_i;
    else if (deliver)
      pc_next = pc_r + xlen_p'(4);
    else
      pc_next = pc_r;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= idle_st;
      imem_req_o <= 1'b0;
      discard_r  <= 1'b0;
      valid_r    <= 1'b0;
      pc_r       <= '0;
    end else begin
      valid_r <= deliver;
      pc_r    <= pc_next;
      if (raise_req) begin
        imem_req_o <= 1'b1;
        state_r    <= wait_ack_st;
      end else if (accept) begin
        imem_req_o <= 1'b0;
        state_r    <= wait_rel_st;
      end
      // the transfer in flight still finishes, but its word is dropped.
      if (accept)
        discard_r <= 1'b0;
      else if (flush_i && state_r == wait_ack_st)
        discard_r <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (raise_req)
      imem_addr_o <= pc_next; // held until the next request.
    if (accept) begin
      word_pc_r <= imem_addr_o;
      word_r    <= imem_data_i;
    end
  end

  always_comb begin
    fetch_o.valid = valid_r;
    fetch_o.pc    = word_pc_r;
    fetch_o.inst  = word_r;
  end

endmodule

/* src/decode_reg_r.sv */
`timescale 1ns/1ps

module decode_reg_r (
    input  logic                  clk_i
  , input  logic                  reset_i
  , input  arm_lite_pkg::fetch_s  fetch_i
  , input  logic                  flush_i
  , input  arm_lite_pkg::wb_s     wb_i
  , output arm_lite_pkg::decode_s decode_o
);
  import arm_lite_pkg::*;

  inst_u                       inst;
  logic [reg_addr_width_p-1:0] r1_addr;
  logic [reg_addr_width_p-1:0] r2_addr;
  logic [xlen_p-1:0]           r1;
  logic [xlen_p-1:0]           r2;

  logic                        valid_r;
  logic [xlen_p-1:0]           pc_r;
  inst_u                       inst_r;
  logic [xlen_p-1:0]           r1_r;
  logic [xlen_p-1:0]           r2_r;
  logic [reg_addr_width_p-1:0] r1_addr_r;
  logic [reg_addr_width_p-1:0] r2_addr_r;
  logic [reg_addr_width_p-1:0] rd_addr_r;

  assign inst = fetch_i.inst;

  // a store needs rd as its data while everything else takes rm.
  assign r1_addr = (inst.dp.inst_class == mem_class) ? inst.dp.rd : inst.dp.rm;
  assign r2_addr = inst.dp.rn;

  register_file i_register_file (
      .clk_i     (clk_i)
    , .reset_i   (reset_i)
    , .r1_addr_i (r1_addr)
    , .r2_addr_i (r2_addr)
    , .pc_i      (fetch_i.pc)
    , .wb_i      (wb_i)
    , .r1_o      (r1)
    , .r2_o      (r2)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i)
      valid_r <= 1'b0;
    else
      valid_r <= fetch_i.valid;
  end

  always_ff @(posedge clk_i) begin
    pc_r      <= fetch_i.pc;
    inst_r    <= inst;
    r1_r      <= r1;
    r2_r      <= r2;
    r1_addr_r <= r1_addr;
    r2_addr_r <= r2_addr;
    rd_addr_r <= inst.dp.rd;
  end

  always_comb begin
    decode_o.valid   = valid_r;
    decode_o.pc      = pc_r;
    decode_o.inst    = inst_r;
    decode_o.r1      = r1_r;
    decode_o.r2      = r2_r;
    decode_o.r1_addr = r1_addr_r;
    decode_o.r2_addr = r2_addr_r;
    decode_o.rd_addr = rd_addr_r;
  end

endmodule

/* src/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
    input  logic                              clk_i
  , input  logic                              reset_i
  , input  arm_lite_pkg::decode_s             decode_i
  , output arm_lite_pkg::wb_s                 wb_o
  , output logic                              flush_o
  , output logic [arm_lite_pkg::xlen_p-1:0]   target_o
  , output arm_lite_pkg::store_s              store_o
);
  import arm_lite_pkg::*;

  inst_u             inst;
  logic              is_dp;
  logic              is_mem;
  logic              is_branch;
  logic [xlen_p-1:0] alu_result;
  logic              alu_valid;
  logic [xlen_p-1:0] branch_offset;

  logic              store_valid_r;
  logic [xlen_p-1:0] store_addr_r;
  logic [xlen_p-1:0] store_data_r;

  assign inst      = decode_i.inst;
  assign is_dp     = decode_i.valid && (inst.dp.inst_class == dp_class);
  assign is_mem    = decode_i.valid && (inst.dp.inst_class == mem_class);
  assign is_branch = decode_i.valid && (inst.br.inst_class == branch_class);

  // r2 holds rn and r1 holds rm.
  always_comb begin
    alu_valid = 1'b1;
    case (inst.dp.opcode)
      and_op: alu_result = decode_i.r2 & decode_i.r1;
      sub_op: alu_result = decode_i.r2 - decode_i.r1;
      add_op: alu_result = decode_i.r2 + decode_i.r1;
      orr_op: alu_result = decode_i.r2 | decode_i.r1;
      mov_op: alu_result = decode_i.r1;
      default: begin
        alu_result = '0;
        alu_valid  = 1'b0; // unsupported opcodes write nothing.
      end
    endcase
  end

  always_comb begin
    wb_o.en   = is_dp && alu_valid;
    wb_o.addr = decode_i.rd_addr;
    wb_o.data = alu_result;
  end

  // the word offset is sign extended and scaled to bytes.
  assign branch_offset = {{(xlen_p-26){inst.br.offset24[23]}}, inst.br.offset24, 2'b00};

  // the branch sees its own pc plus 8.
  assign target_o = decode_i.pc + xlen_p'(8) + branch_offset;
  assign flush_o  = is_branch;

  always_ff @(posedge clk_i) begin
    if (reset_i)
      store_valid_r <= 1'b0;
    else
      store_valid_r <= is_mem;
  end

  always_ff @(posedge clk_i) begin
    if (is_mem) begin
      store_addr_r <= decode_i.r2; // rn is the address.
      store_data_r <= decode_i.r1; // rd is the data.
    end
  end

  always_comb begin
    store_o.valid = store_valid_r;
    store_o.addr  = store_addr_r;
    store_o.data  = store_data_r;
  end

endmodule

/* src/arm_lite_core.sv */
`timescale 1ns/1ps

module arm_lite_core (
    input  logic                              clk_i
  , input  logic                              reset_i
  , output logic                              imem_req_o
  , output logic [arm_lite_pkg::xlen_p-1:0]   imem_addr_o
  , input  logic                              imem_ack_i
  , input  logic [arm_lite_pkg::xlen_p-1:0]   imem_data_i
  , output arm_lite_pkg::store_s              store_o
);
  import arm_lite_pkg::*;

  fetch_s            fetch;
  decode_s           decode;
  wb_s               wb;
  logic              flush;
  logic [xlen_p-1:0] target;

  fetch_unit i_fetch_unit (
      .clk_i       (clk_i)
    , .reset_i     (reset_i)
    , .flush_i     (flush)
    , .target_i    (target)
    , .imem_req_o  (imem_req_o)
    , .imem_addr_o (imem_addr_o)
    , .imem_ack_i  (imem_ack_i)
    , .imem_data_i (imem_data_i)
    , .fetch_o     (fetch)
  );

  decode_reg_r i_decode_reg_r (
      .clk_i    (clk_i)
    , .reset_i  (reset_i)
    , .fetch_i  (fetch)
    , .flush_i  (flush)
    , .wb_i     (wb)
    , .decode_o (decode)
  );

  // writeback loops back into the register file inside decode.
  execute_unit i_execute_unit (
      .clk_i    (clk_i)
    , .reset_i  (reset_i)
    , .decode_i (decode)
    , .wb_o     (wb)
    , .flush_o  (flush)
    , .target_o (target)
    , .store_o  (store_o)
  );

endmodule

/* testbench/arm_lite_core_sva.sv */
`timescale 1ns/1ps

module arm_lite_core_sva (
    input logic                            clk_i
  , input logic                            reset_i
  , input logic                            imem_req_i
  , input logic [arm_lite_pkg::xlen_p-1:0] imem_addr_i
  , input logic                            imem_ack_i
  , input arm_lite_pkg::store_s            store_i
);

  int assert_failures = 0;

  reset_quiet_a: assert property (@(posedge clk_i)
    reset_i |=> !imem_req_i && !store_i.valid)
    else begin
      $error("request or store active right after reset");
      assert_failures++;
    end

  // a new request waits until the previous ack is gone.
  req_after_release_a: assert property (@(posedge clk_i) disable iff (reset_i)
    imem_ack_i && !imem_req_i |=> !imem_req_i)
    else begin
      $error("request raised while ack was still high");
      assert_failures++;
    end

  req_held_a: assert property (@(posedge clk_i) disable iff (reset_i)
    imem_req_i && !imem_ack_i |=> imem_req_i && $stable(imem_addr_i))
    else begin
      $error("request dropped or address changed before ack");
      assert_failures++;
    end

  store_pulse_a: assert property (@(posedge clk_i) disable iff (reset_i)
    store_i.valid |=> !store_i.valid)
    else begin
      $error("store valid held for more than one cycle");
      assert_failures++;
    end

endmodule

bind arm_lite_core arm_lite_core_sva i_core_checker (
    .clk_i       (clk_i)
  , .reset_i     (reset_i)
  , .imem_req_i  (imem_req_o)
  , .imem_addr_i (imem_addr_o)
  , .imem_ack_i  (imem_ack_i)
  , .store_i     (store_o)
);

/* testbench/tb_arm_lite_core.sv */
`timescale 1ns/1ps

module tb_arm_lite_core;
  import arm_lite_pkg::*;

  typedef struct packed {
    logic [1:0]        test;
    logic              last; // final store of its test.
    logic [xlen_p-1:0] addr;
    logic [xlen_p-1:0] data;
  } exp_store_s;

  localparam int prog_words_lp     = 19;
  localparam int num_stores_lp     = 6;
  localparam int num_tests_lp      = 3;
  localparam int num_delays_lp     = 16;
  localparam int timeout_cycles_lp = 40 * prog_words_lp;
  localparam int settle_cycles_lp  = 60;
  localparam logic [xlen_p-1:0] halt_pc_lp = 32'h48;

  logic              clk       = 1'b0;
  logic              reset     = 1'b1;
  logic              imem_ack  = 1'b0;
  logic [xlen_p-1:0] imem_data = '0;
  logic              imem_req;
  logic [xlen_p-1:0] imem_addr;
  store_s            store;

  logic [xlen_p-1:0] program_mem [prog_words_lp];
  exp_store_s        exp_stores [num_stores_lp];
  int                ack_delays [num_delays_lp];
  int                test_errors [num_tests_lp];
  int                req_count;
  int                wait_count;
  int                store_idx;
  int                errors;
  int                cycle_count;

  arm_lite_core i_dut (
      .clk_i       (clk)
    , .reset_i     (reset)
    , .imem_req_o  (imem_req)
    , .imem_addr_o (imem_addr)
    , .imem_ack_i  (imem_ack)
    , .imem_data_i (imem_data)
    , .store_o     (store)
  );

  always #10 clk = ~clk;

  function automatic logic [xlen_p-1:0] dp_word(dp_op_e op, int rd, int rn, int rm);
    return {4'he, 3'b000, op, 1'b0, 4'(rn), 4'(rd), 8'h00, 4'(rm)};
  endfunction

  function automatic logic [xlen_p-1:0] str_word(int rd, int rn);
    return {4'he, 3'b010, 5'b11000, 4'(rn), 4'(rd), 12'h000};
  endfunction

  // the offset counts words from the branch pc plus 8.
  function automatic logic [xlen_p-1:0] branch_word(logic [xlen_p-1:0] pc,
                                                    logic [xlen_p-1:0] target);
    logic [xlen_p-1:0] offset;
    offset = (target - pc - 32'd8) >> 2;
    return {4'he, 3'b101, 1'b0, offset[23:0]};
  endfunction

  function automatic logic [xlen_p-1:0] imem_word(logic [xlen_p-1:0] addr);
    if (addr[xlen_p-1:2] < prog_words_lp)
      return program_mem[addr[xlen_p-1:2]];
    return branch_word(addr, halt_pc_lp); // every unused word jumps to the halt loop.
  endfunction

  function automatic string test_name(int t);
    case (t)
      0: return "alu";
      1: return "bypass";
      default: return "branch";
    endcase
  endfunction

  task automatic load_program();
    program_mem[0]  = dp_word(mov_op, 1, 0, 15);  // r1 = 0x00.
    program_mem[1]  = dp_word(mov_op, 2, 0, 15);  // r2 = 0x04.
    program_mem[2]  = dp_word(mov_op, 3, 0, 15);  // r3 = 0x08.
    program_mem[3]  = dp_word(add_op, 4, 15, 15); // r4 = 0x0c + 0x0c.
    program_mem[4]  = dp_word(add_op, 5, 4, 3);   // r5 = 0x20.
    program_mem[5]  = dp_word(sub_op, 6, 5, 2);   // r6 = 0x1c.
    program_mem[6]  = dp_word(and_op, 7, 6, 4);   // r7 = 0x18.
    program_mem[7]  = dp_word(orr_op, 8, 5, 3);   // r8 = 0x28.
    program_mem[8]  = str_word(5, 4);
    program_mem[9]  = str_word(6, 5);
    program_mem[10] = str_word(7, 6);
    program_mem[11] = str_word(8, 3);
    program_mem[12] = dp_word(add_op, 9, 8, 5);   // r9 = 0x48 is stored right away.
    program_mem[13] = str_word(9, 2);
    program_mem[14] = branch_word(32'h38, 32'h44);
    program_mem[15] = str_word(1, 8);             // a marker that must be skipped.
    program_mem[16] = str_word(1, 7);             // a marker that must be skipped.
    program_mem[17] = str_word(9, 15);            // address is the pc itself.
    program_mem[18] = branch_word(halt_pc_lp, halt_pc_lp);
  endtask

  task automatic set_expected_stores();
    exp_stores[0] = '{2'd0, 1'b0, 32'h18, 32'h20};
    exp_stores[1] = '{2'd0, 1'b0, 32'h20, 32'h1c};
    exp_stores[2] = '{2'd0, 1'b0, 32'h1c, 32'h18};
    exp_stores[3] = '{2'd0, 1'b1, 32'h08, 32'h28};
    exp_stores[4] = '{2'd1, 1'b1, 32'h04, 32'h48};
    exp_stores[5] = '{2'd2, 1'b1, 32'h44, 32'h48};
  endtask

  // the instruction memory acks after a random wait and drops ack once req is gone.
  always @(posedge clk) begin
    if (reset) begin
      imem_ack   <= 1'b0;
      wait_count <= ack_delays[0];
      req_count  <= 1;
    end else if (imem_req && !imem_ack) begin
      if (wait_count == 0) begin
        imem_ack  <= 1'b1;
        imem_data <= imem_word(imem_addr);
      end else begin
        wait_count <= wait_count - 1;
      end
    end else if (!imem_req && imem_ack) begin
      imem_ack   <= 1'b0;
      wait_count <= ack_delays[req_count % num_delays_lp];
      req_count  <= req_count + 1;
    end
  end

  always @(posedge clk) begin
    exp_store_s exp_entry;
    int         bad;
    if (!reset && store.valid) begin
      bad = 0;
      assert (store_idx < num_stores_lp) else begin
        $display("store to address %h came after the last expected store", store.addr);
        bad = 1;
      end
      if (store_idx < num_stores_lp) begin
        exp_entry = exp_stores[store_idx];
        assert (store.addr == exp_entry.addr) else begin
          $display("ERR %s address expected %h actual %h", test_name(exp_entry.test),
                   exp_entry.addr, store.addr);
          bad = bad + 1;
        end
        assert (store.data == exp_entry.data) else begin
          $display("ERR %s data expected %h actual %h", test_name(exp_entry.test),
                   exp_entry.data, store.data);
          bad = bad + 1;
        end
        test_errors[exp_entry.test] <= test_errors[exp_entry.test] + bad;
        if (exp_entry.last)
          $display("test %s finished with %0d errors", test_name(exp_entry.test),
                   test_errors[exp_entry.test] + bad);
      end
      errors    <= errors + bad;
      store_idx <= store_idx + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles_lp) begin
      $display("timeout after %0d cycles with %0d of %0d stores seen", cycle_count,
               store_idx, num_stores_lp);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    int passed;
    int sva_errors;
    void'($urandom(32'hac73_0826));
    for (int i = 0; i < num_delays_lp; i++)
      ack_delays[i] = $urandom_range(3, 0);
    load_program();
    set_expected_stores();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    wait (store_idx >= num_stores_lp);
    repeat (settle_cycles_lp) @(posedge clk); // catch stores that should never appear.
    sva_errors = i_dut.i_core_checker.assert_failures;
    passed = 0;
    for (int t = 0; t < num_tests_lp; t++)
      if (test_errors[t] == 0)
        passed++;
    $display("tests %0d, passed %0d, failed %0d, store errors %0d, assertion failures %0d",
             num_tests_lp, passed, num_tests_lp - passed, errors, sva_errors);
    if (errors == 0 && sva_errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* arm_lite_core.f */
src/arm_lite_pkg.sv
src/register_file.sv
src/fetch_unit.sv
src/decode_reg_r.sv
src/execute_unit.sv
src/arm_lite_core.sv
testbench/arm_lite_core_sva.sv
testbench/tb_arm_lite_core.sv

/* Bender.yml */
package:
  name: arm_lite_core

sources:
  - src/arm_lite_pkg.sv
  - src/register_file.sv
  - src/fetch_unit.sv
  - src/decode_reg_r.sv
  - src/execute_unit.sv
  - src/arm_lite_core.sv
  - target: test
    files:
      - testbench/arm_lite_core_sva.sv
      - testbench/tb_arm_lite_core.sv
